/* run_sim.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module rvseed_tb -f rvseed.f
./obj_dir/Vrvseed_tb 2>&1 | tee sim.log

if grep -q "FAIL: see errors above" sim.log; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

/* rvseed.f */
+incdir+source
source/rvseed_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/rvseed_top.sv
tests/rvseed_checker.sv
tests/rvseed_tb.sv

/* source/alu.sv */
// alu: operand selection and the integer operations, with zero flag
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module alu (
    input  rvseed_pkg::alu_op_e   alu_op,
    input  rvseed_pkg::alu_src_e  alu_src,
    input  logic [`CPU_WIDTH-1:0] rdata1,
    input  logic [`CPU_WIDTH-1:0] rdata2,
    input  logic [`CPU_WIDTH-1:0] imm,
    input  logic [`CPU_WIDTH-1:0] pc,
    output logic [`CPU_WIDTH-1:0] res,
    output logic                  zero
);
    import rvseed_pkg::*;

    logic [`CPU_WIDTH-1:0] src_a;
    logic [`CPU_WIDTH-1:0] src_b;

    always_comb begin
        case (alu_src)
            SRC_REG_IMM:  {src_a, src_b} = {rdata1, imm};
            SRC_PC_IMM:   {src_a, src_b} = {pc, imm};       // auipc
            SRC_ZERO_IMM: {src_a, src_b} = {{`CPU_WIDTH{1'b0}}, imm};
            default:      {src_a, src_b} = {rdata1, rdata2};
        endcase
    end

    always_comb begin
        case (alu_op)
            ALU_ADD:    res = src_a + src_b;
            ALU_SUB:    res = src_a - src_b;
            ALU_AND:    res = src_a & src_b;
            ALU_OR:     res = src_a | src_b;
            ALU_XOR:    res = src_a ^ src_b;
            ALU_SLT:    res = {{(`CPU_WIDTH-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            ALU_PASS_B: res = src_b;
            default:    res = '0;
        endcase
    end

    assign zero = (res == '0);

endmodule

/* source/decoder.sv */
// instruction decoder: control fields, register addresses and immediate
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module decoder (
    input  logic [`CPU_WIDTH-1:0] inst,
    output rvseed_pkg::ctrl_t     ctrl,
    output logic [`CPU_WIDTH-1:0] imm,
    output logic                  unknown_code
);
    import rvseed_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    imm_op_e    imm_op;

    assign opcode = inst[6:0];
    assign funct3 = inst[14:12];
    assign funct7 = inst[31:25];

    always_comb begin
        ctrl         = '0;
        ctrl.rd      = inst[11:7];
        ctrl.rs1     = inst[19:15];
        ctrl.rs2     = inst[24:20];
        ctrl.alu_op  = ALU_ADD;
        ctrl.alu_src = SRC_REG_REG;
        imm_op       = IMM_I;
        unknown_code = 1'b0;
        case (opcode)
            `OPC_LUI: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_op  = ALU_PASS_B;
                ctrl.alu_src = SRC_ZERO_IMM;
                imm_op       = IMM_U;
            end
            `OPC_AUIPC: begin
                ctrl.reg_wen = 1'b1;
                ctrl.alu_src = SRC_PC_IMM;
                imm_op       = IMM_U;
            end
            `OPC_JAL: begin
                ctrl.jump    = 1'b1;
                ctrl.reg_wen = 1'b1;
                ctrl.link    = 1'b1;    // rd gets pc+4, not the alu
                ctrl.alu_src = SRC_PC_IMM;
                imm_op       = IMM_J;
            end
            `OPC_BRANCH: begin
                ctrl.alu_op = ALU_SUB;  // zero flag means rs1 == rs2
                imm_op      = IMM_B;
                case (funct3)
                    `F3_ADD: ctrl.branch = 1'b1;
                    `F3_BNE: begin
                        ctrl.branch    = 1'b1;
                        ctrl.branch_ne = 1'b1;
                    end
                    default: unknown_code = 1'b1;
                endcase
            end
            `OPC_OPIMM: begin
                ctrl.alu_src = SRC_REG_IMM;
                if (funct3 == `F3_ADD) begin
                    ctrl.reg_wen = 1'b1;
                end else begin
                    unknown_code = 1'b1;    // only addi kept
                end
            end
            `OPC_OP: begin
                ctrl.reg_wen = 1'b1;
                case ({funct7, funct3})
                    {`F7_BASE, `F3_ADD}: ctrl.alu_op = ALU_ADD;
                    {`F7_SUB,  `F3_ADD}: ctrl.alu_op = ALU_SUB;
                    {`F7_BASE, `F3_AND}: ctrl.alu_op = ALU_AND;
                    {`F7_BASE, `F3_OR }: ctrl.alu_op = ALU_OR;
                    {`F7_BASE, `F3_XOR}: ctrl.alu_op = ALU_XOR;
                    {`F7_BASE, `F3_SLT}: ctrl.alu_op = ALU_SLT;
                    default: begin
                        ctrl.reg_wen = 1'b0;
                        unknown_code = 1'b1;
                    end
                endcase
            end
            default: unknown_code = 1'b1;
        endcase
    end

    always_comb begin
        case (imm_op)
            IMM_B:   imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            IMM_U:   imm = {inst[31:12], 12'b0};
            IMM_J:   imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default: imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

/* source/fetch_unit.sv */
// fetch unit: pc register, next-pc choice and four-phase instruction fetch
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module fetch_unit (
    input  logic                  clk,
    input  logic                  rst,
    output rvseed_pkg::imem_req_t imem_req,
    input  rvseed_pkg::imem_rsp_t imem_rsp,
    input  rvseed_pkg::ctrl_t     ctrl,
    input  logic [`CPU_WIDTH-1:0] imm,
    input  logic                  zero,
    output logic [`CPU_WIDTH-1:0] inst,
    output logic [`CPU_WIDTH-1:0] pc,
    output logic [`CPU_WIDTH-1:0] pc_plus4,
    output logic                  exec
);
    import rvseed_pkg::*;

    fetch_state_e          state;
    logic [`CPU_WIDTH-1:0] pc_q;
    logic [`CPU_WIDTH-1:0] inst_q;
    logic [`CPU_WIDTH-1:0] next_pc;
    logic                  take;

    assign pc       = pc_q;
    assign pc_plus4 = pc_q + `CPU_WIDTH'd4;
    assign inst     = inst_q;
    assign exec     = (state == FS_EXEC);

    assign imem_req.req  = (state == FS_REQ);
    assign imem_req.addr = pc_q;

    // beq takes on zero, bne on nonzero
    assign take    = ctrl.jump | (ctrl.branch & (zero ^ ctrl.branch_ne));
    assign next_pc = take ? (pc_q + imm) : pc_plus4;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= FS_IDLE;
            pc_q  <= `RESET_PC;
        end else begin
            case (state)
                FS_IDLE: state <= FS_REQ;
                FS_REQ: begin
                    if (imem_rsp.ack) begin
                        state <= FS_RELEASE;    // req drops next cycle
                    end
                end
                FS_RELEASE: begin
                    if (!imem_rsp.ack) begin
                        state <= FS_EXEC;
                    end
                end
                default: begin
                    pc_q  <= next_pc;
                    state <= FS_REQ;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == FS_REQ && imem_rsp.ack) begin
            inst_q <= imem_rsp.data;    // first ack-high cycle only
        end
    end

    a_addr_stable: assert property (@(posedge clk) disable iff (rst)
        (imem_req.req && $past(imem_req.req)) |-> $stable(imem_req.addr));

    // a new request waits for the previous ack to go low
    a_req_after_ack: assert property (@(posedge clk) disable iff (rst)
        $rose(imem_req.req) |-> !$past(imem_rsp.ack));

endmodule

/* source/reg_file.sv */
// register file: 32 general registers, two read ports and one write port
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module reg_file (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       wen,
    input  logic [`REG_ADDR_WIDTH-1:0] waddr,
    input  logic [`CPU_WIDTH-1:0]      wdata,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr1,
    input  logic [`REG_ADDR_WIDTH-1:0] raddr2,
    output logic [`CPU_WIDTH-1:0]      rdata1,
    output logic [`CPU_WIDTH-1:0]      rdata2
);

    logic [`CPU_WIDTH-1:0] regs [1 << `REG_ADDR_WIDTH];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < (1 << `REG_ADDR_WIDTH); i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;   // x0 stays zero
        end
    end

    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

    // holds across every write since reset
    a_x0_zero: assert property (@(posedge clk) disable iff (rst)
        (raddr1 == '0 |-> rdata1 == '0) and (raddr2 == '0 |-> rdata2 == '0));

endmodule

/* source/rvseed_macros.svh */
// rvseed core parameters: widths, reset vector and instruction field codes
`ifndef RVSEED_MACROS_SVH
`define RVSEED_MACROS_SVH

`define CPU_WIDTH        32
`define REG_ADDR_WIDTH   5
`define RESET_PC         32'h0000_0000

// major opcodes, inst[6:0]
`define OPC_LUI          7'b0110111
`define OPC_AUIPC        7'b0010111
`define OPC_JAL          7'b1101111
`define OPC_BRANCH       7'b1100011
`define OPC_OPIMM        7'b0010011
`define OPC_OP           7'b0110011

// funct3 values of the kept instructions
`define F3_ADD           3'b000     // also ADDI, SUB, BEQ
`define F3_BNE           3'b001
`define F3_SLT           3'b010
`define F3_XOR           3'b100
`define F3_OR            3'b110
`define F3_AND           3'b111

`define F7_BASE          7'b0000000
`define F7_SUB           7'b0100000

`endif

/* source/rvseed_pkg.sv */
// rvseed shared types: control encodings, fetch port and retire record
`include "rvseed_macros.svh"

package rvseed_pkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_PASS_B          // LUI result is the immediate itself
    } alu_op_e;

    typedef enum logic [1:0] {
        SRC_REG_REG,
        SRC_REG_IMM,
        SRC_PC_IMM,
        SRC_ZERO_IMM
    } alu_src_e;

    typedef enum logic [1:0] {
        IMM_I,
        IMM_B,
        IMM_U,
        IMM_J
    } imm_op_e;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_REQ,
        FS_RELEASE,
        FS_EXEC
    } fetch_state_e;

    typedef struct packed {
        logic                       branch;
        logic                       branch_ne;  // taken when operands differ
        logic                       jump;
        logic                       reg_wen;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic [`REG_ADDR_WIDTH-1:0] rs1;
        logic [`REG_ADDR_WIDTH-1:0] rs2;
        alu_op_e                    alu_op;
        alu_src_e                   alu_src;
        logic                       link;       // JAL writes pc+4
    } ctrl_t;

    typedef struct packed {
        logic                       req;
        logic [`CPU_WIDTH-1:0]      addr;
    } imem_req_t;

    typedef struct packed {
        logic                       ack;
        logic [`CPU_WIDTH-1:0]      data;
    } imem_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_WIDTH-1:0]      pc;
        logic [`CPU_WIDTH-1:0]      inst;
        logic [`REG_ADDR_WIDTH-1:0] rd;
        logic                       wen;
        logic [`CPU_WIDTH-1:0]      wdata;
        logic                       unknown;
    } retire_t;

endpackage

/* source/rvseed_top.sv */
// rvseed core top: fetch, decode, register file and alu in one execute cycle
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module rvseed_top (
    input  logic                  clk,
    input  logic                  rst,
    output rvseed_pkg::imem_req_t imem_req,
    input  rvseed_pkg::imem_rsp_t imem_rsp,
    output rvseed_pkg::retire_t   retire
);
    import rvseed_pkg::*;

    ctrl_t                 ctrl;
    logic [`CPU_WIDTH-1:0] inst;
    logic [`CPU_WIDTH-1:0] pc;
    logic [`CPU_WIDTH-1:0] pc_plus4;
    logic                  exec;            // one-cycle commit strobe
    logic [`CPU_WIDTH-1:0] imm;
    logic                  unknown_code;
    logic [`CPU_WIDTH-1:0] rdata1;
    logic [`CPU_WIDTH-1:0] rdata2;
    logic [`CPU_WIDTH-1:0] alu_res;
    logic                  zero;
    logic [`CPU_WIDTH-1:0] wb_data;

    assign wb_data = ctrl.link ? pc_plus4 : alu_res;

    fetch_unit u_fetch_unit_0 (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .imem_req ( imem_req ),
        .imem_rsp ( imem_rsp ),
        .ctrl     ( ctrl     ),
        .imm      ( imm      ),
        .zero     ( zero     ),
        .inst     ( inst     ),
        .pc       ( pc       ),
        .pc_plus4 ( pc_plus4 ),
        .exec     ( exec     )
    );

    decoder u_decoder_0 (
        .inst         ( inst         ),
        .ctrl         ( ctrl         ),
        .imm          ( imm          ),
        .unknown_code ( unknown_code )
    );

    reg_file u_reg_file_0 (
        .clk    ( clk                 ),
        .rst    ( rst                 ),
        .wen    ( exec & ctrl.reg_wen ),
        .waddr  ( ctrl.rd             ),
        .wdata  ( wb_data             ),
        .raddr1 ( ctrl.rs1            ),
        .raddr2 ( ctrl.rs2            ),
        .rdata1 ( rdata1              ),
        .rdata2 ( rdata2              )
    );

    alu u_alu_0 (
        .alu_op  ( ctrl.alu_op  ),
        .alu_src ( ctrl.alu_src ),
        .rdata1  ( rdata1       ),
        .rdata2  ( rdata2       ),
        .imm     ( imm          ),
        .pc      ( pc           ),
        .res     ( alu_res      ),
        .zero    ( zero         )
    );

    // writes to x0 are reported as no write
    assign retire = '{
        valid:   exec,
        pc:      pc,
        inst:    inst,
        rd:      ctrl.rd,
        wen:     exec & ctrl.reg_wen & (ctrl.rd != '0),
        wdata:   wb_data,
        unknown: unknown_code
    };

endmodule

/* tests/rvseed_checker.sv */
// rvseed retire checker comparing an ISA reference model with every retired instruction
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module rvseed_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  rvseed_pkg::retire_t   retire,
    input  rvseed_pkg::imem_req_t imem_req,
    input  rvseed_pkg::imem_rsp_t imem_rsp,
    input  logic [`CPU_WIDTH-1:0] prog [64],
    output int                    err_count,
    output int                    retire_count
);
    import rvseed_pkg::*;

    typedef struct packed {
        logic [`CPU_WIDTH-1:0] next_pc;
        logic                  wen;
        logic [`CPU_WIDTH-1:0] wdata;
        logic                  unknown;
    } step_t;

    logic [`CPU_WIDTH-1:0] model_regs [32];
    logic [`CPU_WIDTH-1:0] model_pc = `RESET_PC;
    logic                  req_q = 1'b0;
    logic                  ack_q = 1'b0;
    int                    errors = 0;
    int                    retired = 0;

    assign err_count    = errors;
    assign retire_count = retired;

    // one instruction by the RV32I rules for the kept subset
    function automatic step_t ref_step(input logic [31:0] pc, input logic [31:0] inst,
                                       input logic [31:0] a, input logic [31:0] b);
        step_t       s;
        logic [6:0]  f7;
        logic [2:0]  f3;
        logic [31:0] imm_i;
        logic [31:0] imm_b;
        logic [31:0] imm_u;
        logic [31:0] imm_j;
        f7    = inst[31:25];
        f3    = inst[14:12];
        imm_i = $signed(inst[31:20]);
        imm_b = $signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0});
        imm_u = {inst[31:12], 12'b0};
        imm_j = $signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0});
        s = '{next_pc: pc + 32'd4, wen: 1'b0, wdata: '0, unknown: 1'b0};
        case (inst[6:0])
            `OPC_LUI: s.wdata = imm_u;
            `OPC_AUIPC: s.wdata = pc + imm_u;
            `OPC_JAL: begin
                s.wdata   = pc + 32'd4;     // link value
                s.next_pc = pc + imm_j;
            end
            `OPC_BRANCH: begin
                if ((f3 == 3'b000 && a == b) || (f3 == 3'b001 && a != b)) begin
                    s.next_pc = pc + imm_b;
                end
                s.unknown = (f3 != 3'b000) && (f3 != 3'b001);
            end
            `OPC_OPIMM: begin
                s.wdata   = a + imm_i;
                s.unknown = (f3 != 3'b000);     // addi only
            end
            `OPC_OP: begin
                case ({f7, f3})
                    10'b0000000_000: s.wdata = a + b;
                    10'b0100000_000: s.wdata = a - b;
                    10'b0000000_111: s.wdata = a & b;
                    10'b0000000_110: s.wdata = a | b;
                    10'b0000000_100: s.wdata = a ^ b;
                    10'b0000000_010: s.wdata = {31'b0, $signed(a) < $signed(b)};
                    default:         s.unknown = 1'b1;
                endcase
            end
            default: s.unknown = 1'b1;
        endcase
        s.wen = (inst[6:0] != `OPC_BRANCH) && !s.unknown && (inst[11:7] != 5'd0);
        return s;
    endfunction

    task automatic check_field(input string name, input logic [31:0] want,
                               input logic [31:0] got);
        if (want !== got) begin
            errors++;
            $display("ERR %0t ns %s expected %h actual %h", $time, name, want, got);
        end
    endtask

    // retire and the fetch port sampled mid-cycle
    always @(negedge clk) begin
        step_t       want;
        logic [31:0] want_inst;
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                model_regs[i] = '0;
            end
            model_pc = `RESET_PC;
            retired  = 0;
            if (retire.valid !== 1'b0) begin
                errors++;
                $display("%0t ns: retire valid was not low while reset was held", $time);
            end
        end else begin
            if (imem_req.req && !req_q && ack_q) begin
                errors++;
                $display("%0t ns: fetch request rose while ack was still high", $time);
            end
            if (retire.valid) begin
                want_inst = prog[model_pc[7:2]];    // memory wraps every 64 words
                want = ref_step(model_pc, want_inst, model_regs[want_inst[19:15]],
                                model_regs[want_inst[24:20]]);
                check_field("retire.pc", model_pc, retire.pc);
                check_field("retire.inst", want_inst, retire.inst);
                check_field("retire.rd", 32'(want_inst[11:7]), 32'(retire.rd));
                check_field("retire.wen", 32'(want.wen), 32'(retire.wen));
                check_field("retire.unknown", 32'(want.unknown), 32'(retire.unknown));
                if (want.wen) begin
                    check_field("retire.wdata", want.wdata, retire.wdata);
                    model_regs[want_inst[11:7]] = want.wdata;
                end
                model_pc = want.next_pc;
                retired++;
            end
        end
        req_q = imem_req.req;
        ack_q = imem_rsp.ack;
    end

endmodule

/* tests/rvseed_tb.sv */
// rvseed testbench with clock, reset, instruction memory with random ack delay and programs
`timescale 1ns/10ps
`include "rvseed_macros.svh"

module rvseed_tb;
    import rvseed_pkg::*;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int NUM_DIRECTED = 42;       // two passes of the directed loop
    localparam int NUM_RANDOM   = 200;
    localparam int TIMEOUT_NS   = (NUM_DIRECTED + NUM_RANDOM) * 12 * CLK_PERIOD
                                  + 2 * RESET_CYCLES * CLK_PERIOD;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    imem_req_t             imem_req;
    imem_rsp_t             imem_rsp = '0;
    retire_t               retire;
    logic [`CPU_WIDTH-1:0] prog [64];
    logic [31:0]           lcg_state = 32'd81;
    int                    ack_delay = 0;
    logic                  pending = 1'b0;  // request seen and delay drawn
    int                    err_count;
    int                    retire_count;
    int                    total_retired = 0;

    always #(CLK_PERIOD / 2) clk = ~clk;

    rvseed_top rvseed_top_inst (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .imem_req ( imem_req ),
        .imem_rsp ( imem_rsp ),
        .retire   ( retire   )
    );

    rvseed_checker checker_inst (
        .clk          ( clk          ),
        .rst          ( rst          ),
        .retire       ( retire       ),
        .imem_req     ( imem_req     ),
        .imem_rsp     ( imem_rsp     ),
        .prog         ( prog         ),
        .err_count    ( err_count    ),
        .retire_count ( retire_count )
    );

    function automatic logic [31:0] rand16();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return {16'b0, lcg_state[31:16]};   // upper half of the lcg state
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                          input int rd, input int rs1, input int rs2);
        return {f7, rs2[4:0], rs1[4:0], f3, rd[4:0], `OPC_OP};
    endfunction

    function automatic logic [31:0] enc_i(input logic [2:0] f3, input int rd,
                                          input int rs1, input int imm);
        return {imm[11:0], rs1[4:0], f3, rd[4:0], `OPC_OPIMM};
    endfunction

    function automatic logic [31:0] enc_b(input logic [2:0] f3, input int rs1,
                                          input int rs2, input int off);
        logic [12:0] o;
        o = off[12:0];
        return {o[12], o[10:5], rs2[4:0], rs1[4:0], f3, o[4:1], o[11], `OPC_BRANCH};
    endfunction

    function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm20);
        return {imm20[19:0], rd[4:0], opc};
    endfunction

    function automatic logic [31:0] enc_j(input int rd, input int off);
        logic [20:0] o;
        o = off[20:0];
        return {o[20], o[10:1], o[11], o[19:12], rd[4:0], `OPC_JAL};
    endfunction

    // four-phase slave answering after 0 to 3 cycles
    always @(posedge clk) begin
        #5;
        if (imem_rsp.ack) begin
            if (!imem_req.req) imem_rsp.ack = 1'b0;
        end else if (!imem_req.req) begin
            pending = 1'b0;
        end else begin
            if (!pending) begin
                pending   = 1'b1;
                ack_delay = int'(rand16() % 4);
            end
            if (ack_delay == 0) begin
                imem_rsp.ack  = 1'b1;
                imem_rsp.data = prog[imem_req.addr[7:2]];
                pending       = 1'b0;
            end else begin
                ack_delay--;
            end
        end
    end

    task automatic load_directed();
        for (int i = 0; i < 64; i++) begin
            prog[i] = {16'hDEAD, 2'b00, 6'(i), 8'h7F};  // illegal opcode tagged by word
        end
        prog[0]  = enc_i(`F3_ADD, 1, 0, 5);
        prog[1]  = enc_i(`F3_ADD, 2, 0, -3);
        prog[2]  = enc_r(`F7_BASE, `F3_ADD, 3, 1, 2);
        prog[3]  = enc_r(`F7_SUB, `F3_ADD, 4, 2, 1);
        prog[4]  = enc_r(`F7_BASE, `F3_AND, 5, 1, 2);
        prog[5]  = enc_r(`F7_BASE, `F3_OR, 6, 1, 2);
        prog[6]  = enc_r(`F7_BASE, `F3_XOR, 7, 1, 2);
        prog[7]  = enc_r(`F7_BASE, `F3_SLT, 8, 2, 1);  // negative below positive
        prog[8]  = enc_r(`F7_BASE, `F3_SLT, 9, 1, 2);
        prog[9]  = enc_u(`OPC_LUI, 10, 'hABCDE);
        prog[10] = enc_u(`OPC_AUIPC, 11, 'h12345);
        prog[11] = enc_b(`F3_ADD, 1, 1, 8);             // beq taken
        prog[12] = enc_i(`F3_ADD, 12, 0, 1);
        prog[13] = enc_b(`F3_BNE, 1, 1, 8);             // bne not taken
        prog[14] = enc_b(`F3_BNE, 1, 2, 8);             // bne taken
        prog[15] = enc_i(`F3_ADD, 12, 0, 2);
        prog[16] = enc_b(`F3_ADD, 1, 2, 8);             // beq not taken
        prog[17] = enc_j(13, 8);
        prog[18] = enc_i(`F3_ADD, 12, 0, 3);
        prog[19] = enc_i(`F3_ADD, 0, 1, 7);             // write to x0
        prog[20] = enc_r(`F7_BASE, `F3_ADD, 14, 0, 1);
        prog[21] = 32'hFFFF_FFFF;
        prog[22] = enc_i(3'b001, 15, 1, 1);             // slli is not kept
        prog[23] = enc_j(0, -92);                       // back to word 0
    endtask

    task automatic load_random();
        int kind;
        int rd;
        int rs1;
        int rs2;
        int off;
        for (int i = 0; i < 64; i++) begin
            kind = int'(rand16() % 14);
            rd   = int'(rand16() % 8);      // small register set with x0
            rs1  = int'(rand16() % 8);
            rs2  = int'(rand16() % 8);
            off  = int'(rand16() % 63 + 1);
            off  = (((i + off) % 64) - i) * 4;  // target inside the 64 words and never itself
            case (kind)
                0:       prog[i] = enc_r(`F7_BASE, `F3_ADD, rd, rs1, rs2);
                1:       prog[i] = enc_r(`F7_SUB, `F3_ADD, rd, rs1, rs2);
                2:       prog[i] = enc_r(`F7_BASE, `F3_AND, rd, rs1, rs2);
                3:       prog[i] = enc_r(`F7_BASE, `F3_OR, rd, rs1, rs2);
                4:       prog[i] = enc_r(`F7_BASE, `F3_XOR, rd, rs1, rs2);
                5:       prog[i] = enc_r(`F7_BASE, `F3_SLT, rd, rs1, rs2);
                6:       prog[i] = enc_u(`OPC_LUI, rd, int'(rand16() ^ (rand16() << 4)));
                7:       prog[i] = enc_u(`OPC_AUIPC, rd, int'(rand16()));
                8:       prog[i] = enc_b(`F3_ADD, rs1, rs2, off);
                9:       prog[i] = enc_b(`F3_BNE, rs1, rs2, off);
                10:      prog[i] = enc_j(rd, off);
                default: prog[i] = enc_i(`F3_ADD, rd, rs1, int'(rand16()));
            endcase
        end
    endtask

    // entered at time zero or right after a rising edge
    task automatic run_phase(input logic random_prog, input int count);
        #5 rst = 1'b1;
        if (random_prog) begin
            load_random();
        end else begin
            load_directed();
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #5 rst = 1'b0;
        while (retire_count < count) @(posedge clk);
        total_retired += retire_count;
    endtask

    initial begin
        run_phase(1'b0, NUM_DIRECTED);
        run_phase(1'b1, NUM_RANDOM);
        $display("retired %0d instructions, %0d errors", total_retired, err_count);
        if (err_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: the core stopped retiring before all tests were done");
        $display("FAIL: see errors above");
        $finish;
    end

endmodule
